//--- design/game_pkg.sv
//##########################################################
// well geometry and spawn point of the falling piece
// action indices and the per-action request vector
// orientation, position and lock count types
//##########################################################

package game_pkg;

    // well size in cells with the origin at the top left
    localparam int WELL_ROWS   = 20;
    localparam int WELL_COLS   = 10;

    // a new piece appears here
    localparam int SPAWN_ROW   = 0;
    localparam int SPAWN_COL   = 4;

    localparam int NUM_ACTIONS = 6;

    typedef logic [4:0] row_t;
    typedef logic [4:0] col_t;

    // clockwise order so a right rotation is +1
    typedef enum logic [1:0] {
        ORIENT_SPAWN   = 2'd0,
        ORIENT_RIGHT   = 2'd1,
        ORIENT_REVERSE = 2'd2,
        ORIENT_LEFT    = 2'd3
    } orientation_t;

    // bit positions in an action_vec_t
    typedef enum logic [2:0] {
        ACT_MOVE_RIGHT   = 3'd0,
        ACT_MOVE_LEFT    = 3'd1,
        ACT_ROTATE_RIGHT = 3'd2,
        ACT_ROTATE_LEFT  = 3'd3,
        ACT_SOFT_DROP    = 3'd4,
        ACT_HARD_DROP    = 3'd5
    } action_e;

    typedef logic [NUM_ACTIONS-1:0] action_vec_t;

    typedef logic [7:0] lock_count_t;

endpackage

//--- design/timing_pkg.sv
//##########################################################
// delayed auto shift timing in milliseconds
// radixes and types of the sprint timer digits
//##########################################################

package timing_pkg;

    // ms ticks before the first repeat, then between repeats
    localparam int DAS_DELAY_MS     = 167;
    localparam int AUTO_REPEAT_MS   = 33;

    localparam int DIGIT_RADIX_DEC  = 10;
    localparam int DIGIT_RADIX_SEXA = 60;

    typedef logic [3:0] ms_digit_t;
    typedef logic [5:0] sexa_digit_t;

    // wide enough for the longer of the two delays
    typedef logic [$clog2(DAS_DELAY_MS + 1)-1:0] das_count_t;

endpackage

//--- design/input_decoder.sv
//##########################################################
// key synchronizers and mode switch latch
// mapping of held keys to per-action requests
//##########################################################

module input_decoder
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        key_left,
    input  logic        key_right,
    input  logic        key_down,
    input  logic        key_drop,
    input  logic        mode_rotate,
    output action_vec_t action_req
);

    // key bits {drop, down, left, right} are active high after the first flop
    logic [3:0]  key_meta;
    logic [3:0]  key_held;
    logic        mode_q;
    action_vec_t req_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_meta   <= '0;
            key_held   <= '0;
            mode_q     <= 1'b0;
            action_req <= '0;
        end else begin
            key_meta   <= ~{key_drop, key_down, key_left, key_right};
            key_held   <= key_meta;
            // a held key keeps the meaning it was pressed with
            if (!(|key_held)) begin
                mode_q <= mode_rotate;
            end
            action_req <= req_next;
        end
    end

    always_comb begin
        req_next                   = '0;
        req_next[ACT_MOVE_RIGHT]   = key_held[0] && !mode_q;
        req_next[ACT_MOVE_LEFT]    = key_held[1] && !mode_q;
        req_next[ACT_ROTATE_RIGHT] = key_held[0] && mode_q;
        req_next[ACT_ROTATE_LEFT]  = key_held[1] && mode_q;
        req_next[ACT_SOFT_DROP]    = key_held[2];
        // drop key does nothing in rotate mode
        req_next[ACT_HARD_DROP]    = key_held[3] && !mode_q;
    end

endmodule

//--- design/das_channel.sv
//##########################################################
// delayed auto shift for a single action
// fires on press, waits the initial delay, then repeats
// while the request is held and the action is allowed
//##########################################################

module das_channel
    import timing_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic ms_tick,
    input  logic req,
    input  logic allowed,
    output logic fire
);

    logic       first_done;
    logic       repeating;
    das_count_t count;
    das_count_t last_count;

    // initial delay until the first repeat and a shorter period after that
    assign last_count = repeating ? das_count_t'(AUTO_REPEAT_MS - 1)
                                  : das_count_t'(DAS_DELAY_MS - 1);

    always_ff @(posedge clk) begin
        if (!rst_n || !req) begin
            first_done <= 1'b0;
            repeating  <= 1'b0;
            count      <= '0;
            fire       <= 1'b0;
        end else begin
            fire <= 1'b0;
            if (!first_done) begin
                // press fires at once, but only once it is legal
                if (allowed) begin
                    fire       <= 1'b1;
                    first_done <= 1'b1;
                    count      <= '0;
                end
            end else if (allowed && ms_tick) begin
                if (count == last_count) begin
                    fire      <= 1'b1;
                    repeating <= 1'b1;
                    count     <= '0;
                end else begin
                    count <= count + 1'b1;
                end
            end
            // a blocked tick holds the count and its repeat is lost
        end
    end

    // allowed is read one cycle after the fire decision
    a_fire_only_when_allowed: assert property (
        @(posedge clk) disable iff (!rst_n)
        fire |-> allowed
    ) else $error("das_channel fired while the action was blocked");

endmodule

//--- design/piece_controller.sv
//##########################################################
// bounds checks of the falling piece against an empty well
// priority pick of one fired action per cycle
// origin row, column and orientation registers, lock count
//##########################################################

module piece_controller
    import game_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  action_vec_t  action_fire,
    output action_vec_t  action_allowed,
    output row_t         piece_row,
    output col_t         piece_col,
    output orientation_t piece_orientation,
    output lock_count_t  pieces_locked
);

    action_vec_t applied;

    // with no locked tiles the legality is just the well border
    always_comb begin
        action_allowed                   = '0;
        action_allowed[ACT_MOVE_RIGHT]   = piece_col < col_t'(WELL_COLS - 1);
        action_allowed[ACT_MOVE_LEFT]    = piece_col != '0;
        action_allowed[ACT_ROTATE_RIGHT] = 1'b1;
        action_allowed[ACT_ROTATE_LEFT]  = 1'b1;
        action_allowed[ACT_SOFT_DROP]    = piece_row < row_t'(WELL_ROWS - 1);
        action_allowed[ACT_HARD_DROP]    = 1'b1;
    end

    // an illegal fire is dropped here as well
    assign applied = action_fire & action_allowed;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            piece_row         <= row_t'(SPAWN_ROW);
            piece_col         <= col_t'(SPAWN_COL);
            piece_orientation <= ORIENT_SPAWN;
            pieces_locked     <= '0;
        end else if (applied[ACT_HARD_DROP]) begin
            // lock in place and bring in the next piece
            piece_row         <= row_t'(SPAWN_ROW);
            piece_col         <= col_t'(SPAWN_COL);
            piece_orientation <= ORIENT_SPAWN;
            pieces_locked     <= pieces_locked + 1'b1;
        end else if (applied[ACT_SOFT_DROP]) begin
            piece_row <= piece_row + 1'b1;
        end else if (applied[ACT_MOVE_RIGHT]) begin
            piece_col <= piece_col + 1'b1;
        end else if (applied[ACT_MOVE_LEFT]) begin
            piece_col <= piece_col - 1'b1;
        end else if (applied[ACT_ROTATE_RIGHT]) begin
            piece_orientation <= orientation_t'(piece_orientation + 2'd1);
        end else if (applied[ACT_ROTATE_LEFT]) begin
            piece_orientation <= orientation_t'(piece_orientation - 2'd1);
        end
    end

    a_col_in_well: assert property (
        @(posedge clk) disable iff (!rst_n)
        piece_col < col_t'(WELL_COLS)
    ) else $error("piece column left the well");

    a_row_in_well: assert property (
        @(posedge clk) disable iff (!rst_n)
        piece_row < row_t'(WELL_ROWS)
    ) else $error("piece row left the well");

endmodule

//--- design/sprint_timer.sv
//##########################################################
// free running millisecond prescaler
// sprint timer with cascaded ms, cs, ds, seconds, minutes
//##########################################################

module sprint_timer
    import timing_pkg::*;
#(
    parameter int CLK_PER_MS = 50_000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        timer_start,
    input  logic        timer_stop,
    output logic        ms_tick,
    output logic        timer_running,
    output ms_digit_t   time_ms,
    output ms_digit_t   time_cs,
    output ms_digit_t   time_ds,
    output sexa_digit_t time_sec,
    output sexa_digit_t time_min
);

    typedef logic [$clog2(CLK_PER_MS)-1:0] prescale_t;

    prescale_t prescale;
    logic      ms_en;
    logic      cs_en;
    logic      ds_en;
    logic      sec_en;
    logic      min_en;

    // one step of a digit that wraps at its radix
    function automatic logic [5:0] step_digit(input logic [5:0] value, input int radix);
        if (value == 6'(radix - 1)) begin
            return '0;
        end
        return value + 6'd1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prescale <= '0;
            ms_tick  <= 1'b0;
        end else if (prescale == prescale_t'(CLK_PER_MS - 1)) begin
            prescale <= '0;
            ms_tick  <= 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
            ms_tick  <= 1'b0;
        end
    end

    // each digit rolls the next one over at its top value
    assign ms_en  = timer_running && ms_tick;
    assign cs_en  = ms_en && (time_ms == ms_digit_t'(DIGIT_RADIX_DEC - 1));
    assign ds_en  = cs_en && (time_cs == ms_digit_t'(DIGIT_RADIX_DEC - 1));
    assign sec_en = ds_en && (time_ds == ms_digit_t'(DIGIT_RADIX_DEC - 1));
    assign min_en = sec_en && (time_sec == sexa_digit_t'(DIGIT_RADIX_SEXA - 1));

    always_ff @(posedge clk) begin
        if (!rst_n || timer_start) begin
            // start wins over a stop in the same cycle
            timer_running <= rst_n && timer_start;
            time_ms       <= '0;
            time_cs       <= '0;
            time_ds       <= '0;
            time_sec      <= '0;
            time_min      <= '0;
        end else begin
            if (timer_stop) begin
                timer_running <= 1'b0;
            end
            if (ms_en) begin
                time_ms <= ms_digit_t'(step_digit(6'(time_ms), DIGIT_RADIX_DEC));
            end
            if (cs_en) begin
                time_cs <= ms_digit_t'(step_digit(6'(time_cs), DIGIT_RADIX_DEC));
            end
            if (ds_en) begin
                time_ds <= ms_digit_t'(step_digit(6'(time_ds), DIGIT_RADIX_DEC));
            end
            if (sec_en) begin
                time_sec <= step_digit(time_sec, DIGIT_RADIX_SEXA);
            end
            if (min_en) begin
                time_min <= step_digit(time_min, DIGIT_RADIX_SEXA);
            end
        end
    end

    a_digits_in_radix: assert property (
        @(posedge clk) disable iff (!rst_n)
        (time_ms < ms_digit_t'(DIGIT_RADIX_DEC)) &&
        (time_cs < ms_digit_t'(DIGIT_RADIX_DEC)) &&
        (time_ds < ms_digit_t'(DIGIT_RADIX_DEC)) &&
        (time_sec < sexa_digit_t'(DIGIT_RADIX_SEXA)) &&
        (time_min < sexa_digit_t'(DIGIT_RADIX_SEXA))
    ) else $error("timer digit beyond its radix");

endmodule

//--- design/tetris_input_top.sv
//##########################################################
// top level of the player input path and sprint timer
// key decoder, one auto shift channel per action,
// piece controller and timer
//##########################################################

module tetris_input_top
    import game_pkg::*,
           timing_pkg::*;
#(
    parameter int CLK_PER_MS = 50_000
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         key_left,
    input  logic         key_right,
    input  logic         key_down,
    input  logic         key_drop,
    input  logic         mode_rotate,
    input  logic         timer_start,
    input  logic         timer_stop,
    output row_t         piece_row,
    output col_t         piece_col,
    output orientation_t piece_orientation,
    output lock_count_t  pieces_locked,
    output ms_digit_t    time_ms,
    output ms_digit_t    time_cs,
    output ms_digit_t    time_ds,
    output sexa_digit_t  time_sec,
    output sexa_digit_t  time_min,
    output logic         timer_running
);

    action_vec_t action_req;
    action_vec_t action_allowed;
    action_vec_t action_fire;
    logic        ms_tick;

    input_decoder i_input_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_left    (key_left),
        .key_right   (key_right),
        .key_down    (key_down),
        .key_drop    (key_drop),
        .mode_rotate (mode_rotate),
        .action_req  (action_req)
    );

    for (genvar i = 0; i < NUM_ACTIONS; i++) begin : g_das
        das_channel i_das_channel (
            .clk     (clk),
            .rst_n   (rst_n),
            .ms_tick (ms_tick),
            .req     (action_req[i]),
            .allowed (action_allowed[i]),
            .fire    (action_fire[i])
        );
    end

    piece_controller i_piece_controller (
        .clk               (clk),
        .rst_n             (rst_n),
        .action_fire       (action_fire),
        .action_allowed    (action_allowed),
        .piece_row         (piece_row),
        .piece_col         (piece_col),
        .piece_orientation (piece_orientation),
        .pieces_locked     (pieces_locked)
    );

    // also the ms time base of the auto shift channels
    sprint_timer #(
        .CLK_PER_MS (CLK_PER_MS)
    ) i_sprint_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .timer_start   (timer_start),
        .timer_stop    (timer_stop),
        .ms_tick       (ms_tick),
        .timer_running (timer_running),
        .time_ms       (time_ms),
        .time_cs       (time_cs),
        .time_ds       (time_ds),
        .time_sec      (time_sec),
        .time_min      (time_min)
    );

endmodule

//--- tb/tb_tetris_input_top.sv
//##########################################################
// testbench of the player input path and sprint timer
// reference position model, key taps and timer run
//##########################################################

module tb_tetris_input_top
    import game_pkg::*,
           timing_pkg::*;
();

    localparam int CLK_PER_MS = 5;
    localparam int KEY_RIGHT  = 0;
    localparam int KEY_LEFT   = 1;
    localparam int KEY_DOWN   = 2;
    localparam int KEY_DROP   = 3;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         key_left;
    logic         key_right;
    logic         key_down;
    logic         key_drop;
    logic         mode_rotate;
    logic         timer_start;
    logic         timer_stop;
    row_t         piece_row;
    col_t         piece_col;
    orientation_t piece_orientation;
    lock_count_t  pieces_locked;
    ms_digit_t    time_ms;
    ms_digit_t    time_cs;
    ms_digit_t    time_ds;
    sexa_digit_t  time_sec;
    sexa_digit_t  time_min;
    logic         timer_running;

    // reference model of the piece
    row_t         m_row;
    col_t         m_col;
    orientation_t m_orient;
    lock_count_t  m_locked;

    int   errors = 0;
    int   tests = 0;
    int   failed_tests = 0;
    int   errors_at_start = 0;
    int   cycle_count = 0;
    int   tick_count = 0;
    int   last_total = 0;
    logic was_running = 1'b0;
    logic tick_window = 1'b0;
    logic wall_hold = 1'b0;
    logic frozen = 1'b0;

    tetris_input_top #(
        .CLK_PER_MS (CLK_PER_MS)
    ) i_tetris_input_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .key_left          (key_left),
        .key_right         (key_right),
        .key_down          (key_down),
        .key_drop          (key_drop),
        .mode_rotate       (mode_rotate),
        .timer_start       (timer_start),
        .timer_stop        (timer_stop),
        .piece_row         (piece_row),
        .piece_col         (piece_col),
        .piece_orientation (piece_orientation),
        .pieces_locked     (pieces_locked),
        .time_ms           (time_ms),
        .time_cs           (time_cs),
        .time_ds           (time_ds),
        .time_sec          (time_sec),
        .time_min          (time_min),
        .timer_running     (timer_running)
    );

    always #10 clk = ~clk;

    // ms ticks counted from our own reset-aligned cycle count
    always @(posedge clk) begin
        if (!rst_n) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
            if (tick_window && cycle_count != 0 && cycle_count % CLK_PER_MS == 0) begin
                tick_count <= tick_count + 1;
            end
        end
    end

    function automatic int digits_total();
        return int'(time_ms) + 10 * int'(time_cs) + 100 * int'(time_ds)
               + 1000 * int'(time_sec) + 60000 * int'(time_min);
    endfunction

    // timer digits only ever step by one millisecond while running
    always @(negedge clk) begin
        int total;
        total = digits_total();
        if (rst_n) begin
            assert (time_ms < 4'd10 && time_cs < 4'd10 && time_ds < 4'd10
                    && time_sec < 6'd60 && time_min < 6'd60) else begin
                errors++;
                $display("a timer digit went beyond its radix");
            end
            if (timer_running && was_running) begin
                assert (total == last_total || total == last_total + 1) else begin
                    errors++;
                    $display("ERR time total: got %h expected %h", total, last_total + 1);
                end
            end
        end
        last_total  = total;
        was_running = timer_running;
    end

    a_wall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wall_hold |-> (piece_col == '0) && $stable(piece_row) && $stable(piece_orientation)
    ) else begin
        errors++;
        $display("ERR piece_col: got %h expected %h", piece_col, 5'h0);
    end

    a_timer_start: assert property (@(posedge clk) disable iff (!rst_n)
        timer_start |=> timer_running
    ) else begin
        errors++;
        $display("ERR timer_running: got %h expected %h", timer_running, 1'b1);
    end

    a_timer_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        frozen |-> $stable(time_ms) && $stable(time_cs) && $stable(time_ds)
                   && $stable(time_sec) && $stable(time_min) && !timer_running
    ) else begin
        errors++;
        $display("timer digits moved after the timer was stopped");
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected) else begin
            errors++;
            $display("ERR %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic check_model();
        @(negedge clk);
        check_equal("piece_row", 32'(piece_row), 32'(m_row));
        check_equal("piece_col", 32'(piece_col), 32'(m_col));
        check_equal("piece_orientation", 32'(piece_orientation), 32'(m_orient));
        check_equal("pieces_locked", 32'(pieces_locked), 32'(m_locked));
    endtask

    // bounds and priority rules of an empty well
    task automatic model_apply(input action_e act);
        case (act)
            ACT_HARD_DROP: begin
                m_row    = row_t'(SPAWN_ROW);
                m_col    = col_t'(SPAWN_COL);
                m_orient = ORIENT_SPAWN;
                m_locked = m_locked + 8'd1;
            end
            ACT_SOFT_DROP: if (m_row < row_t'(WELL_ROWS - 1)) m_row = m_row + 5'd1;
            ACT_MOVE_RIGHT: if (m_col < col_t'(WELL_COLS - 1)) m_col = m_col + 5'd1;
            ACT_MOVE_LEFT: if (m_col != '0) m_col = m_col - 5'd1;
            ACT_ROTATE_RIGHT: m_orient = orientation_t'(m_orient + 2'd1);
            ACT_ROTATE_LEFT: m_orient = orientation_t'(m_orient - 2'd1);
            default: ;
        endcase
    endtask

    task automatic wait_for_model(input int timeout);
        int n;
        n = 0;
        @(negedge clk);
        while ((piece_row != m_row || piece_col != m_col || piece_orientation != m_orient
                || pieces_locked != m_locked) && n < timeout) begin
            @(negedge clk);
            n++;
        end
        if (n >= timeout) begin
            errors++;
            $display("timeout: the piece never reached the expected state");
        end
    endtask

    task automatic set_key(input int which, input logic level);
        case (which)
            KEY_RIGHT: key_right <= level;
            KEY_LEFT:  key_left  <= level;
            KEY_DOWN:  key_down  <= level;
            default:   key_drop  <= level;
        endcase
    endtask

    // press, wait for the response, optionally flip the mode, release
    task automatic tap_key(input int which, input logic flip_mode, input int wait_limit,
                           input int hold);
        @(posedge clk);
        set_key(which, 1'b0);
        wait_for_model(wait_limit);
        @(posedge clk);
        if (flip_mode) mode_rotate <= ~mode_rotate;
        repeat (hold) @(posedge clk);
        set_key(which, 1'b1);
        repeat (10) @(posedge clk);
        check_model();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", tests, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        int n;
        rst_n       = 1'b0;
        key_left    = 1'b1;
        key_right   = 1'b1;
        key_down    = 1'b1;
        key_drop    = 1'b1;
        mode_rotate = 1'b0;
        timer_start = 1'b0;
        timer_stop  = 1'b0;
        m_row       = row_t'(SPAWN_ROW);
        m_col       = col_t'(SPAWN_COL);
        m_orient    = ORIENT_SPAWN;
        m_locked    = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        check_model();
        check_equal("digits total", 32'(digits_total()), 32'd0);
        check_equal("timer_running", 32'(timer_running), 32'd0);
        end_test("reset state");

        model_apply(ACT_MOVE_RIGHT);
        tap_key(KEY_RIGHT, 1'b0, 40, 40);
        model_apply(ACT_SOFT_DROP);
        tap_key(KEY_DOWN, 1'b0, 40, 40);
        end_test("short presses");

        // long hold of left slides the piece into the wall
        while (m_col != '0) model_apply(ACT_MOVE_LEFT);
        @(posedge clk);
        key_left <= 1'b0;
        wait_for_model(3000);
        @(posedge clk);
        wall_hold <= 1'b1;
        repeat (400) @(posedge clk);
        wall_hold <= 1'b0;
        key_left  <= 1'b1;
        repeat (10) @(posedge clk);
        check_model();
        end_test("auto repeat and wall");

        @(posedge clk);
        mode_rotate <= 1'b1;
        repeat (5) @(posedge clk);
        model_apply(ACT_ROTATE_RIGHT);
        tap_key(KEY_RIGHT, 1'b0, 40, 40);
        model_apply(ACT_ROTATE_LEFT);
        tap_key(KEY_LEFT, 1'b0, 40, 40);
        model_apply(ACT_ROTATE_LEFT);
        tap_key(KEY_LEFT, 1'b0, 40, 40);
        check_equal("piece_orientation", 32'(piece_orientation), 32'(ORIENT_LEFT));
        // mode flips to move while right is held
        model_apply(ACT_ROTATE_RIGHT);
        tap_key(KEY_RIGHT, 1'b1, 40, 40);
        end_test("rotation and mode latch");

        model_apply(ACT_HARD_DROP);
        tap_key(KEY_DROP, 1'b0, 40, 40);
        @(posedge clk);
        mode_rotate <= 1'b1;
        repeat (5) @(posedge clk);
        tap_key(KEY_DROP, 1'b0, 40, 40);
        @(posedge clk);
        mode_rotate <= 1'b0;
        end_test("hard drop");

        @(posedge clk);
        timer_start <= 1'b1;
        tick_window <= 1'b1;
        @(posedge clk);
        timer_start <= 1'b0;
        n = 0;
        while (digits_total() < 1100 && n < 8000) begin
            @(negedge clk);
            n++;
        end
        if (n >= 8000) begin
            errors++;
            $display("timeout: the timer never reached 1100 ms");
        end
        @(posedge clk);
        timer_stop  <= 1'b1;
        tick_window <= 1'b0;
        @(posedge clk);
        timer_stop <= 1'b0;
        n = 0;
        while (timer_running && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (n >= 20) begin
            errors++;
            $display("timeout: the timer kept running after stop");
        end
        @(posedge clk);
        frozen <= 1'b1;
        repeat (200) @(posedge clk);
        frozen <= 1'b0;
        @(negedge clk);
        n = digits_total() - tick_count;
        assert (n >= -1 && n <= 1) else begin
            errors++;
            $display("ERR time total: got %h expected %h", digits_total(), tick_count);
        end
        end_test("sprint timer");

        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sources.f
design/game_pkg.sv
design/timing_pkg.sv
design/input_decoder.sv
design/das_channel.sv
design/piece_controller.sv
design/sprint_timer.sv
design/tetris_input_top.sv
tb/tb_tetris_input_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compiles the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_tetris_input_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

output=$(./obj_dir/Vtb_tetris_input_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
